// ==== verilog/corr_params.svh ====
`ifndef CORR_PARAMS_SVH
`define CORR_PARAMS_SVH

// --------------------------------------------------------------------------
//  Array geometry
// --------------------------------------------------------------------------
`define CORR_ANTS    8     // Antennas, one re and one im bit each
`define CORR_SLOTS   12    // Pairs per round, also the round length
`define CORR_SLOT_W  4     // Slot index width
`define CORR_ACC_W   8     // Accumulator width, small so that wrap is reachable
`define CORR_ADR_W   5     // Bus address, component bit on top of slot

// --------------------------------------------------------------------------
//  Pair table
// --------------------------------------------------------------------------
`define CORR_IDX_W   3     // Antenna index width
`define CORR_PAIR_W  6     // One table entry, {b, a}

// Slot 0 sits in the low bits, a index in the low half of each entry
`define CORR_PAIRS { \
   3'd7, 3'd6,  3'd7, 3'd5,  3'd6, 3'd5, \
   3'd7, 3'd4,  3'd6, 3'd4,  3'd5, 3'd4, \
   3'd3, 3'd2,  3'd3, 3'd1,  3'd2, 3'd1, \
   3'd3, 3'd0,  3'd2, 3'd0,  3'd1, 3'd0  \
}

`endif

// ==== verilog/corr_pkg.sv ====
`include "corr_params.svh"

package corr_pkg;

   // -----------------------------------------------------------------------
   //  Data types shared by sequencer, lanes and readout
   // -----------------------------------------------------------------------
   typedef logic [`CORR_ANTS-1:0]   ant_t;   // One bit per antenna
   typedef logic [`CORR_SLOT_W-1:0] slot_t;  // Pair slot within a round
   typedef logic [`CORR_ACC_W-1:0]  acc_t;   // Agreement count

   // Bank and clear control of the sequencer
   typedef enum logic [1:0] {
      SEQ_CLEAR     = 2'd0,  // First round of a fresh bank, old values read as zero
      SEQ_RUN       = 2'd1,  // Plain accumulation
      SEQ_SWAP_PEND = 2'd2   // Swap requested, waits for end of round
   } corr_state_e;

   // Component field of the bus address
   typedef enum logic {
      COMP_COS = 1'b0,       // re(a) against re(b)
      COMP_SIN = 1'b1        // re(a) against im(b)
   } corr_comp_e;

endpackage

// ==== verilog/corr_if.sv ====
`timescale 1ns/1ps

// Sample path from the sequencer to both accumulator lanes.
// Every field is registered on the accepting edge, so all of them
// describe the same sample during the cycle where go is high.
interface corr_if;
   import corr_pkg::*;

   logic  go;      // Sample strobe, one cycle per accepted sample
   slot_t slot;    // Pair slot of this sample
   logic  bank;    // Active bank at acceptance
   logic  clear;   // Old value counts as zero
   logic  a_re;    // Real bit of antenna a
   logic  b_re;    // Real bit of antenna b
   logic  b_im;    // Imaginary bit of antenna b

   // Sequencer side
   modport seq (
      output go,
      output slot,
      output bank,
      output clear,
      output a_re,
      output b_re,
      output b_im
   );

   // Lane side
   modport lane (
      input go,
      input slot,
      input bank,
      input clear,
      input a_re,
      input b_re,
      input b_im
   );

endinterface

// ==== verilog/corr_sequencer.sv ====
`timescale 1ns/1ps
`include "corr_params.svh"

module corr_sequencer (
   input  logic           clk_x,
   input  logic           rst,
   input  logic           en_i,    // Sample valid
   input  logic           sw_i,    // Bank swap request, one-cycle pulse
   input  corr_pkg::ant_t re_i,    // Real bits of all antennas
   input  corr_pkg::ant_t im_i,    // Imaginary bits of all antennas
   corr_if.seq            bus_o
);
   import corr_pkg::*;

   localparam logic [`CORR_SLOTS*`CORR_PAIR_W-1:0] PAIRS = `CORR_PAIRS;

   slot_t                  slot_q;       // Slot of the next sample
   logic                   bank_q;       // Bank being accumulated
   logic                   clr_q;        // Current round restarts from zero
   corr_state_e            state_q;
   logic                   last_w;       // Slot 11
   logic                   acc_last_w;   // Accepting edge in slot 11
   logic                   swap_w;       // Flip bank at this edge
   logic [`CORR_PAIR_W-1:0] pair_w;
   logic [`CORR_IDX_W-1:0] a_idx_w;
   logic [`CORR_IDX_W-1:0] b_idx_w;

   // --------------------------------------------------------------------------
   //  Slot counter, one step per accepted sample
   // --------------------------------------------------------------------------
   assign last_w     = (slot_q == slot_t'(`CORR_SLOTS - 1));
   assign acc_last_w = en_i && last_w;

   always_ff @(posedge clk_x) begin
      if (rst) begin
         slot_q <= '0;
      end else if (en_i) begin
         slot_q <= last_w ? '0 : slot_q + 1'b1;   // Wrap 11 -> 0
      end
   end

   // --------------------------------------------------------------------------
   //  Bank, swap and clear control
   // --------------------------------------------------------------------------
   // A request on the same edge as the last sample still counts
   assign swap_w = acc_last_w && (sw_i || (state_q == SEQ_SWAP_PEND));

   always_ff @(posedge clk_x) begin
      if (rst) begin
         state_q <= SEQ_CLEAR;
         bank_q  <= 1'b0;
         clr_q   <= 1'b1;                  // Bank 0 starts from zero
      end else if (swap_w) begin
         state_q <= SEQ_CLEAR;
         bank_q  <= ~bank_q;               // Round ends, new bank takes over
         clr_q   <= 1'b1;
      end else begin
         case (state_q)
            SEQ_CLEAR: begin
               if (sw_i) begin
                  state_q <= SEQ_SWAP_PEND;  // clr_q stays until round end
               end else if (acc_last_w) begin
                  state_q <= SEQ_RUN;
                  clr_q   <= 1'b0;           // Fresh bank fully written once
               end
            end
            SEQ_RUN: begin
               if (sw_i) begin
                  state_q <= SEQ_SWAP_PEND;
               end
            end
            SEQ_SWAP_PEND: begin
               // Held until swap_w fires at slot 11
               state_q <= SEQ_SWAP_PEND;
            end
            default: begin
               state_q <= SEQ_CLEAR;
            end
         endcase
      end
   end

   // --------------------------------------------------------------------------
   //  Pair lookup and sample register
   // --------------------------------------------------------------------------
   assign pair_w  = PAIRS[slot_q*`CORR_PAIR_W +: `CORR_PAIR_W];
   assign a_idx_w = pair_w[`CORR_IDX_W-1:0];
   assign b_idx_w = pair_w[`CORR_PAIR_W-1:`CORR_IDX_W];

   always_ff @(posedge clk_x) begin
      if (rst) begin
         bus_o.go <= 1'b0;
      end else begin
         bus_o.go <= en_i;
      end
   end

   // Payload follows every cycle, only looked at while go is high
   always_ff @(posedge clk_x) begin
      bus_o.slot  <= slot_q;
      bus_o.bank  <= bank_q;     // Value before any flip on this edge
      bus_o.clear <= clr_q;
      bus_o.a_re  <= re_i[a_idx_w];
      bus_o.b_re  <= re_i[b_idx_w];
      bus_o.b_im  <= im_i[b_idx_w];
   end

endmodule

// ==== verilog/corr_lane.sv ====
`timescale 1ns/1ps
`include "corr_params.svh"

module corr_lane #(
   parameter bit SIN_LANE = 1'b0   // 1 compares re(a) with im(b)
) (
   input  logic            clk_x,
   input  logic            rst,
   corr_if.lane            bus_i,
   input  corr_pkg::slot_t rd_slot_i,   // Bus-side read slot
   input  logic            rd_bank_i,   // Bus-side read bank
   output corr_pkg::acc_t  rd_data_o,
   output logic            ovf_o        // Sticky carry out
);
   import corr_pkg::*;

   acc_t                  mem_q [2][`CORR_SLOTS];   // Bank x slot
   acc_t                  old_q;       // Value read for the sample in flight
   logic                  inc_q;       // Bits agreed
   logic                  wr_q;        // Write stage valid
   logic                  wr_bank_q;
   slot_t                 wr_slot_q;
   logic                  b_bit_w;
   logic                  agree_w;
   logic [`CORR_ACC_W:0]  sum_w;       // Extra bit is the carry

   // --------------------------------------------------------------------------
   //  One-bit correlation
   // --------------------------------------------------------------------------
   assign b_bit_w = SIN_LANE ? bus_i.b_im : bus_i.b_re;
   assign agree_w = ~(bus_i.a_re ^ b_bit_w);       // XNOR of the sign bits

   // --------------------------------------------------------------------------
   //  Read stage
   // --------------------------------------------------------------------------
   // Edge where go is high, one cycle after acceptance
   always_ff @(posedge clk_x) begin
      if (bus_i.go) begin
         old_q     <= bus_i.clear ? '0 : mem_q[bus_i.bank][bus_i.slot];
         inc_q     <= agree_w;
         wr_bank_q <= bus_i.bank;
         wr_slot_q <= bus_i.slot;
      end
   end

   always_ff @(posedge clk_x) begin
      if (rst) begin
         wr_q <= 1'b0;
      end else begin
         wr_q <= bus_i.go;
      end
   end

   // --------------------------------------------------------------------------
   //  Add and write stage
   // --------------------------------------------------------------------------
   assign sum_w = {1'b0, old_q} + {{`CORR_ACC_W{1'b0}}, inc_q};

   // Lands two cycles after acceptance. The next sample reads
   // another slot on the same edge, so no bypass is needed
   always_ff @(posedge clk_x) begin
      if (wr_q) begin
         mem_q[wr_bank_q][wr_slot_q] <= sum_w[`CORR_ACC_W-1:0];
      end
   end

   always_ff @(posedge clk_x) begin
      if (rst) begin
         ovf_o <= 1'b0;
      end else if (wr_q && sum_w[`CORR_ACC_W]) begin
         ovf_o <= 1'b1;                             // Held until reset
      end
   end

   // --------------------------------------------------------------------------
   //  Bus read port
   // --------------------------------------------------------------------------
   // Combinational, the readout registers the selected value.
   // Out-of-range slots are masked there
   assign rd_data_o = mem_q[rd_bank_i][rd_slot_i];

endmodule

// ==== verilog/vis_readout.sv ====
`timescale 1ns/1ps
`include "corr_params.svh"

module vis_readout (
   input  logic                   clk_x,
   input  logic                   rst,
   input  logic                   stb_i,       // Request strobe
   input  logic                   we_i,        // Write, acknowledged but not stored
   input  logic [`CORR_ADR_W-1:0] adr_i,       // {component, slot}
   input  logic                   bank_i,      // Active bank
   input  corr_pkg::acc_t         cos_data_i,
   input  corr_pkg::acc_t         sin_data_i,
   output corr_pkg::slot_t        rd_slot_o,
   output logic                   rd_bank_o,
   output logic                   ack_o,
   output corr_pkg::acc_t         dat_o
);
   import corr_pkg::*;

   corr_comp_e comp_w;       // Component field of the address
   logic       in_range_w;   // Slot 0 to 11
   acc_t       sel_w;

   // --------------------------------------------------------------------------
   //  Address decode
   // --------------------------------------------------------------------------
   assign rd_slot_o  = adr_i[`CORR_SLOT_W-1:0];
   assign rd_bank_o  = ~bank_i;                  // Always the idle bank
   assign comp_w     = corr_comp_e'(adr_i[`CORR_ADR_W-1]);
   assign in_range_w = (rd_slot_o < slot_t'(`CORR_SLOTS));

   always_comb begin
      case (comp_w)
         COMP_COS: sel_w = cos_data_i;
         COMP_SIN: sel_w = sin_data_i;
         default:  sel_w = cos_data_i;
      endcase
   end

   // --------------------------------------------------------------------------
   //  Response
   // --------------------------------------------------------------------------
   // Every strobe is acknowledged on the next cycle, writes included
   always_ff @(posedge clk_x) begin
      if (rst) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= stb_i;
      end
   end

   // Sampled on the strobe edge. Writes and slots 12 to 15 return zero
   always_ff @(posedge clk_x) begin
      if (stb_i) begin
         dat_o <= (we_i || !in_range_w) ? '0 : sel_w;
      end
   end

endmodule

// ==== verilog/correlator_top.sv ====
`timescale 1ns/1ps
`include "corr_params.svh"

module correlator_top (
   input  logic                   clk_x,
   input  logic                   rst,

   // Sample side
   input  logic                   en_i,       // Sample valid
   input  logic                   sw_i,       // Swap banks at end of round
   input  corr_pkg::ant_t         re_i,
   input  corr_pkg::ant_t         im_i,

   // Bus side
   input  logic                   stb_i,
   input  logic                   we_i,       // Ignored apart from the ack
   input  logic [`CORR_ADR_W-1:0] adr_i,
   output logic                   ack_o,
   output corr_pkg::acc_t         dat_o,

   // Sticky overflow per lane
   output logic                   ovf_cos_o,
   output logic                   ovf_sin_o
);
   import corr_pkg::*;

   slot_t rd_slot_w;        // Read slot, shared by both lanes
   logic  rd_bank_w;        // Inactive bank
   acc_t  cos_data_w;
   acc_t  sin_data_w;

   corr_if u_bus ();        // Sequencer to lanes

   // --------------------------------------------------------------------------
   //  Sample path
   // --------------------------------------------------------------------------
   corr_sequencer u_seq (
      .clk_x (clk_x),
      .rst   (rst),
      .en_i  (en_i),
      .sw_i  (sw_i),
      .re_i  (re_i),
      .im_i  (im_i),
      .bus_o (u_bus.seq)
   );

   corr_lane #(.SIN_LANE(1'b0)) COS_LANE (
      .clk_x     (clk_x),
      .rst       (rst),
      .bus_i     (u_bus.lane),
      .rd_slot_i (rd_slot_w),
      .rd_bank_i (rd_bank_w),
      .rd_data_o (cos_data_w),
      .ovf_o     (ovf_cos_o)
   );

   corr_lane #(.SIN_LANE(1'b1)) SIN_LANE (
      .clk_x     (clk_x),
      .rst       (rst),
      .bus_i     (u_bus.lane),
      .rd_slot_i (rd_slot_w),
      .rd_bank_i (rd_bank_w),
      .rd_data_o (sin_data_w),
      .ovf_o     (ovf_sin_o)
   );

   // --------------------------------------------------------------------------
   //  Bus read port
   // --------------------------------------------------------------------------
   vis_readout u_readout (
      .clk_x      (clk_x),
      .rst        (rst),
      .stb_i      (stb_i),
      .we_i       (we_i),
      .adr_i      (adr_i),
      .bank_i     (u_bus.bank),   // Registered bank, follows the last write
      .cos_data_i (cos_data_w),
      .sin_data_i (sin_data_w),
      .rd_slot_o  (rd_slot_w),
      .rd_bank_o  (rd_bank_w),
      .ack_o      (ack_o),
      .dat_o      (dat_o)
   );

endmodule

// ==== dv/correlator_assertions.sv ====
`timescale 1ns/1ps
`include "corr_params.svh"

// Pipeline, bank and bus timing rules of the correlator
module correlator_assertions (
   input  logic            clk_x,
   input  logic            rst,
   input  logic            en_i,       // Sample accepted on this edge
   input  logic            go_i,       // Registered sample strobe
   input  corr_pkg::slot_t slot_i,     // Slot of the sample on the bus
   input  logic            bank_i,     // Bank of the sample on the bus
   input  logic            cos_wr_i,   // Write stage of the cosine lane
   input  logic            sin_wr_i,   // Write stage of the sine lane
   input  logic            stb_i,
   input  logic            ack_o
);

   int fail_count = 0;   // Failed assertions so far

   // Accept, then go, then the write one cycle after that
   a_write_after_go : assert property (@(posedge clk_x) disable iff (rst)
      en_i |=> go_i ##1 (cos_wr_i && sin_wr_i))
      else begin
         $error("lane write missing two cycles after an accepted sample");
         fail_count++;
      end

   // Bank flips only behind the accepted sample of the last slot
   a_bank_at_round_end : assert property (@(posedge clk_x) disable iff (rst)
      (bank_i != $past(bank_i)) |->
         ($past(go_i) && ($past(slot_i) == corr_pkg::slot_t'(`CORR_SLOTS - 1))))
      else begin
         $error("bank changed outside the end of a round");
         fail_count++;
      end

   a_ack_after_stb : assert property (@(posedge clk_x) disable iff (rst)
      stb_i |=> ack_o)
      else begin
         $error("no ack one cycle after a strobe");
         fail_count++;
      end

endmodule

// Top scope sees both lanes and the bus port at once
bind correlator_top correlator_assertions u_assert (
   .clk_x    (clk_x),
   .rst      (rst),
   .en_i     (en_i),
   .go_i     (u_bus.go),
   .slot_i   (u_bus.slot),
   .bank_i   (u_bus.bank),
   .cos_wr_i (COS_LANE.wr_q),
   .sin_wr_i (SIN_LANE.wr_q),
   .stb_i    (stb_i),
   .ack_o    (ack_o)
);

// ==== dv/correlator_tb.sv ====
`timescale 1ns/1ps
`include "corr_params.svh"

module correlator_tb;
   import corr_pkg::*;

   localparam int CLK_HALF   = 50;        // 100 ns period
   localparam int DRIVE_DLY  = 5;         // Inputs change after the edge
   localparam int RST_CYCLES = 8;
   localparam int N_TESTS    = 6;
   localparam int SETTLE     = 3;         // Writes land two cycles after acceptance
   localparam int BUS_BUDGET = 256;       // Reads, write probe and rereads of one test
   localparam int MARGIN     = 200;
   localparam logic [`CORR_SLOTS*`CORR_PAIR_W-1:0] PAIRS = `CORR_PAIRS;

   logic                   clk_x;
   logic                   rst;
   logic                   en_i;
   logic                   sw_i;
   ant_t                   re_i;
   ant_t                   im_i;
   logic                   stb_i;
   logic                   we_i;
   logic [`CORR_ADR_W-1:0] adr_i;
   logic                   ack_o;
   acc_t                   dat_o;
   logic                   ovf_cos_o;
   logic                   ovf_sin_o;

   // Test table, one column per array
   string t_name     [N_TESTS];
   int    t_rounds   [N_TESTS];
   bit    t_agree    [N_TESTS];    // 1 all-agree samples, 0 LFSR samples
   int    t_gap      [N_TESTS];    // Idle cycles after every sample
   int    t_sw_slot  [N_TESTS];    // sw_i pulse slot in the last round
   bit    t_replay   [N_TESTS];    // Same samples as the entry before
   bit    t_wr_probe [N_TESTS];
   bit    t_ovf_cos  [N_TESTS];
   bit    t_ovf_sin  [N_TESTS];

   // Reference model state
   acc_t        mdl_cos [2][`CORR_SLOTS];
   acc_t        mdl_sin [2][`CORR_SLOTS];
   bit          mdl_bank;
   bit          mdl_clear;
   bit          mdl_pend;
   int          mdl_slot;

   acc_t        this_reads [2*`CORR_SLOTS];
   acc_t        last_reads [2*`CORR_SLOTS];
   logic [15:0] lfsr;
   logic [15:0] entry_seed [N_TESTS];
   int          cycles      = 0;
   int          cycle_limit = 0;

   correlator_top UUT (
      .clk_x     (clk_x),
      .rst       (rst),
      .en_i      (en_i),
      .sw_i      (sw_i),
      .re_i      (re_i),
      .im_i      (im_i),
      .stb_i     (stb_i),
      .we_i      (we_i),
      .adr_i     (adr_i),
      .ack_o     (ack_o),
      .dat_o     (dat_o),
      .ovf_cos_o (ovf_cos_o),
      .ovf_sin_o (ovf_sin_o)
   );

   initial begin
      clk_x = 1'b0;
      forever #CLK_HALF clk_x = ~clk_x;
   end

   // --------------------------------------------------------------------------
   //  Failure handling and compare tasks
   // --------------------------------------------------------------------------
   task automatic fail_stop(input string why);
      $display("%s", why);
      $display("Something failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_acc(input string name, input acc_t exp, input acc_t act);
      if (act !== exp) begin
         fail_stop($sformatf("error %s: expected %0d, actual %0d", name, exp, act));
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         fail_stop($sformatf("error %s: expected %b, actual %b", name, exp, act));
      end
   endtask

   // Run limit from the table, and the bound pipeline rules
   always @(posedge clk_x) begin
      cycles++;
      if (UUT.u_assert.fail_count != 0) begin
         fail_stop("a pipeline, bank or bus timing assertion failed");
      end else if (cycle_limit > 0 && cycles > cycle_limit) begin
         fail_stop($sformatf("timeout, run still busy after %0d cycles", cycles));
      end
   end

   function automatic int run_budget();
      int total;
      total = RST_CYCLES + MARGIN;
      for (int i = 0; i < N_TESTS; i++) begin
         total += t_rounds[i] * `CORR_SLOTS * (1 + t_gap[i]) + 1 + SETTLE + BUS_BUDGET;
      end
      return total;
   endfunction

   // --------------------------------------------------------------------------
   //  Stimulus source and pair table lookup
   // --------------------------------------------------------------------------
   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic fb;
      fb = s[15] ^ s[13] ^ s[12] ^ s[10];
      return {s[14:0], fb};
   endfunction

   task automatic take_ant(output ant_t v);
      for (int k = 0; k < `CORR_ANTS; k++) begin
         lfsr = lfsr_next(lfsr);          // One step per bit
         v[k] = lfsr[0];
      end
   endtask

   function automatic int pair_a(input int s);
      return int'(PAIRS[s*`CORR_PAIR_W +: `CORR_IDX_W]);
   endfunction

   function automatic int pair_b(input int s);
      return int'(PAIRS[s*`CORR_PAIR_W + `CORR_IDX_W +: `CORR_IDX_W]);
   endfunction

   task automatic set_entry(input int i, input string name, input int rounds,
                            input bit agree, input int gap, input int sw_slot,
                            input bit replay, input bit wr_probe,
                            input bit ovf_c, input bit ovf_s);
      t_name[i]     = name;
      t_rounds[i]   = rounds;
      t_agree[i]    = agree;
      t_gap[i]      = gap;
      t_sw_slot[i]  = sw_slot;
      t_replay[i]   = replay;
      t_wr_probe[i] = wr_probe;
      t_ovf_cos[i]  = ovf_c;
      t_ovf_sin[i]  = ovf_s;
   endtask

   task automatic load_table();
      //        name          rnd  agr gap sw  rep wrp oc  os
      set_entry(0, "random",   4,  0,  0,  11, 0,  0,  0,  0);
      set_entry(1, "reuse_b1", 3,  0,  0,  11, 0,  0,  0,  0);
      set_entry(2, "gaps",     3,  0,  2,  11, 1,  0,  0,  0);   // Bank 0 reused
      set_entry(3, "mid_swap", 2,  0,  0,  5,  0,  0,  0,  0);
      set_entry(4, "overflow", 260, 1, 0,  11, 0,  0,  1,  1);
      set_entry(5, "bus_wr",   1,  0,  1,  11, 0,  1,  1,  1);   // Flags stay sticky
   endtask

   // --------------------------------------------------------------------------
   //  Reference model
   // --------------------------------------------------------------------------
   task automatic model_reset();
      for (int b = 0; b < 2; b++) begin
         for (int s = 0; s < `CORR_SLOTS; s++) begin
            mdl_cos[b][s] = '0;
            mdl_sin[b][s] = '0;
         end
      end
      mdl_bank  = 1'b0;
      mdl_clear = 1'b1;                   // Bank 0 fresh out of reset
      mdl_pend  = 1'b0;
      mdl_slot  = 0;
   endtask

   task automatic model_sample(input ant_t re, input ant_t im, input logic sw);
      int   a;
      int   b;
      acc_t old_c;
      acc_t old_s;
      a     = pair_a(mdl_slot);
      b     = pair_b(mdl_slot);
      old_c = mdl_clear ? '0 : mdl_cos[mdl_bank][mdl_slot];
      old_s = mdl_clear ? '0 : mdl_sin[mdl_bank][mdl_slot];
      mdl_cos[mdl_bank][mdl_slot] = old_c + acc_t'(re[a] == re[b]);   // Wraps at 256
      mdl_sin[mdl_bank][mdl_slot] = old_s + acc_t'(re[a] == im[b]);
      if (sw) mdl_pend = 1'b1;
      if (mdl_slot == `CORR_SLOTS - 1) begin
         if (mdl_pend) begin
            mdl_bank  = !mdl_bank;         // New bank restarts at zero
            mdl_clear = 1'b1;
            mdl_pend  = 1'b0;
         end else begin
            mdl_clear = 1'b0;
         end
         mdl_slot = 0;
      end else begin
         mdl_slot++;
      end
   endtask

   // --------------------------------------------------------------------------
   //  DUT drivers
   // --------------------------------------------------------------------------
   task automatic drive_cycle(input logic en, input logic sw, input ant_t re, input ant_t im);
      @(posedge clk_x);
      #DRIVE_DLY;
      en_i = en;
      sw_i = sw;
      re_i = re;
      im_i = im;
   endtask

   // One strobe, ack expected exactly one cycle later
   task automatic bus_cycle(input string name, input logic we,
                            input logic [`CORR_ADR_W-1:0] adr, output acc_t data);
      @(posedge clk_x);
      #DRIVE_DLY;
      check_flag({name, " ack idle"}, 1'b0, ack_o);
      stb_i = 1'b1;
      we_i  = we;
      adr_i = adr;
      @(posedge clk_x);
      #DRIVE_DLY;
      stb_i = 1'b0;
      we_i  = 1'b0;
      check_flag({name, " ack"}, 1'b1, ack_o);
      data = dat_o;
   endtask

   // All 32 addresses, slots 12 to 15 must read zero
   task automatic read_all(input string name);
      acc_t  d;
      acc_t  exp;
      string tag;
      for (int c = 0; c < 2; c++) begin
         for (int s = 0; s < 16; s++) begin
            tag = $sformatf("%s %s slot %0d", name, (c == 1) ? "sin" : "cos", s);
            bus_cycle(tag, 1'b0, {c[0], s[`CORR_SLOT_W-1:0]}, d);
            if (s >= `CORR_SLOTS) begin
               exp = '0;
            end else begin
               exp = (c == 1) ? mdl_sin[!mdl_bank][s] : mdl_cos[!mdl_bank][s];
               this_reads[c*`CORR_SLOTS + s] = d;
            end
            check_acc(tag, exp, d);
         end
      end
   endtask

   task automatic write_probe(input string name);
      acc_t d;
      for (int c = 0; c < 2; c++) begin
         for (int s = 0; s < `CORR_SLOTS; s++) begin
            bus_cycle($sformatf("%s write %0d.%0d", name, c, s), 1'b1,
                      {c[0], s[`CORR_SLOT_W-1:0]}, d);
         end
      end
   endtask

   // --------------------------------------------------------------------------
   //  One table entry
   // --------------------------------------------------------------------------
   task automatic run_entry(input int idx);
      ant_t re;
      ant_t im;
      logic sw;
      if (t_replay[idx] && idx > 0) lfsr = entry_seed[idx-1];   // Same samples again
      entry_seed[idx] = lfsr;
      $display("test %s: %0d rounds, gap %0d", t_name[idx], t_rounds[idx], t_gap[idx]);
      for (int r = 0; r < t_rounds[idx]; r++) begin
         for (int s = 0; s < `CORR_SLOTS; s++) begin
            if (t_agree[idx]) begin
               re = '1;
               im = '1;
            end else begin
               take_ant(re);
               take_ant(im);
            end
            sw = (r == t_rounds[idx] - 1) && (s == t_sw_slot[idx]);
            drive_cycle(1'b1, sw, re, im);
            model_sample(re, im, sw);
            repeat (t_gap[idx]) drive_cycle(1'b0, 1'b0, ~re, ~im);   // Idle data ignored
         end
      end
      repeat (1 + SETTLE) drive_cycle(1'b0, 1'b0, '0, '0);
      read_all(t_name[idx]);
      if (t_wr_probe[idx]) begin
         write_probe(t_name[idx]);
         read_all({t_name[idx], " after write"});
      end
      if (t_replay[idx]) begin
         for (int i = 0; i < 2*`CORR_SLOTS; i++) begin
            check_acc($sformatf("%s against no-gap run %0d", t_name[idx], i),
                      last_reads[i], this_reads[i]);
         end
      end
      check_flag({t_name[idx], " ovf_cos"}, t_ovf_cos[idx], ovf_cos_o);
      check_flag({t_name[idx], " ovf_sin"}, t_ovf_sin[idx], ovf_sin_o);
      last_reads = this_reads;
   endtask

   initial begin
      rst    = 1'b1;
      en_i   = 1'b0;
      sw_i   = 1'b0;
      re_i   = '0;
      im_i   = '0;
      stb_i  = 1'b0;
      we_i   = 1'b0;
      adr_i  = '0;
      lfsr   = 16'd15930;
      load_table();
      cycle_limit = run_budget();
      model_reset();
      repeat (RST_CYCLES) @(posedge clk_x);
      #DRIVE_DLY;
      rst = 1'b0;
      check_flag("reset ack_o", 1'b0, ack_o);
      check_flag("reset ovf_cos", 1'b0, ovf_cos_o);
      check_flag("reset ovf_sin", 1'b0, ovf_sin_o);
      for (int i = 0; i < N_TESTS; i++) begin
         run_entry(i);
      end
      if (UUT.u_assert.fail_count == 0) begin
         $display("Everything OK");
         $finish;
      end else begin
         fail_stop("pipeline, bank or bus timing assertions failed");
      end
   end

endmodule

// ==== all.f ====
+incdir+verilog
verilog/corr_pkg.sv
verilog/corr_if.sv
verilog/corr_sequencer.sv
verilog/corr_lane.sv
verilog/vis_readout.sv
verilog/correlator_top.sv
dv/correlator_assertions.sv
dv/correlator_tb.sv
